//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_sc_mul -o tb_sc_mul

# simulator status is ignored here; the pass line decides
sim_out=$(./obj_dir/tb_sc_mul 2>&1 || true)
echo "$sim_out"

if grep -q "Regression passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

//--- sim.f
+incdir+src
src/sc_pkg.sv
src/sc_counter.sv
src/sc_phase_ctrl.sv
src/sn_stream_reg.sv
src/sc_accum_bank.sv
src/sc_result_stage.sv
src/sc_mul_top.sv
test/sc_mul_assert.sv
test/tb_sc_mul.sv

//--- src/sc_accum_bank.sv
`timescale 1ns/10ps
`include "sc_defs.svh"

module sc_accum_bank (
  input  logic            clk,
  input  logic            rst,
  input  logic            clr,
  input  logic            en,
  input  sc_pkg::stream_t stream_a,
  input  sc_pkg::stream_t stream_b,
  output sc_pkg::result_t sum
);

  import sc_pkg::*;

  logic [`SC_LEN-1:0]    lane_hit;
  logic [`SC_LANE_W-1:0] lane_cnt [`SC_LEN];

  assign lane_hit = stream_a & stream_b & {`SC_LEN{en}};  // bitwise product

  for (genvar i = 0; i < `SC_LEN; i++) begin : g_lane
    sc_counter #(
      .WIDTH (`SC_LANE_W)
    ) u_lane (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .en       (lane_hit[i]),
      .count    (lane_cnt[i]),
      .overflow ()  // a lane never passes 16
    );
  end

  // total of all lanes is the exact product
  always_comb begin
    sum = '0;
    for (int i = 0; i < `SC_LEN; i++) begin
      sum = sum + result_t'(lane_cnt[i]);
    end
  end

endmodule

//--- src/sc_counter.sv
`timescale 1ns/10ps

module sc_counter #(
  parameter int WIDTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clr,
  input  logic             en,
  output logic [WIDTH-1:0] count,
  output logic             overflow
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (clr) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (en) begin
      count    <= count + 1'b1;
      overflow <= &count;  // set on the wrapping edge
    end
  end

endmodule

//--- src/sc_defs.svh
`ifndef SC_DEFS_SVH
`define SC_DEFS_SVH

// operand width, one stream bit per operand code
`define SC_OPW 4
`define SC_LEN 16

// a lane can reach 16
`define SC_LANE_W 5

// product plus offset, wraps mod 256
`define SC_RESW 8

`endif

//--- src/sc_mul_top.sv
`timescale 1ns/10ps

module sc_mul_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  sc_pkg::operand_t in_a,
  input  sc_pkg::operand_t in_b,
  input  sc_pkg::result_t  in_c,
  input  logic             out_ready,
  output logic             in_ready,
  output logic             out_valid,
  output sc_pkg::result_t  out_data
);

  import sc_pkg::*;

  logic     start;
  logic     fill;
  logic     rotate;
  logic     finish;
  logic     res_full;
  operand_t ramp;
  operand_t op_a;
  operand_t op_b;
  stream_t  stream_a;
  stream_t  stream_b;
  result_t  sum;

  sc_phase_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_a     (in_a),
    .in_b     (in_b),
    .res_full (res_full),
    .in_ready (in_ready),
    .start    (start),
    .fill     (fill),
    .rotate   (rotate),
    .finish   (finish),
    .ramp     (ramp),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  // fill wins over rotate, so a's stream is filled and then holds
  sn_stream_reg strm_a (
    .clk    (clk),
    .rst    (rst),
    .level  (op_a),
    .ramp   (ramp),
    .fill   (fill),
    .rotate (fill),
    .stream (stream_a)
  );

  sn_stream_reg strm_b (
    .clk    (clk),
    .rst    (rst),
    .level  (op_b),
    .ramp   (ramp),
    .fill   (fill),
    .rotate (rotate),
    .stream (stream_b)
  );

  sc_accum_bank u_bank (
    .clk      (clk),
    .rst      (rst),
    .clr      (start),
    .en       (rotate),
    .stream_a (stream_a),
    .stream_b (stream_b),
    .sum      (sum)
  );

  sc_result_stage u_res (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .finish    (finish),
    .in_c      (in_c),
    .sum       (sum),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .res_full  (res_full)
  );

endmodule

//--- src/sc_phase_ctrl.sv
`timescale 1ns/10ps
`include "sc_defs.svh"

module sc_phase_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  sc_pkg::operand_t in_a,
  input  sc_pkg::operand_t in_b,
  input  logic             res_full,
  output logic             in_ready,
  output logic             start,
  output logic             fill,
  output logic             rotate,
  output logic             finish,
  output sc_pkg::operand_t ramp,
  output sc_pkg::operand_t op_a,
  output sc_pkg::operand_t op_b
);

  import sc_pkg::*;

  sc_phase_t state;
  sc_phase_t state_nxt;
  logic      ramp_en;
  logic      ramp_ovf;

  assign in_ready = (state == IDLE);
  assign start    = in_valid & in_ready;
  assign fill     = (state == LOAD);
  assign rotate   = (state == MUL);
  assign finish   = (state == DONE) & ~res_full;  // output register must be free

  // counting from the acceptance edge puts the overflow one edge
  // ahead of the phase boundary, so LOAD and MUL last 16 edges each
  assign ramp_en = start | fill | rotate;

  sc_counter #(
    .WIDTH (`SC_OPW)
  ) u_ramp (
    .clk      (clk),
    .rst      (rst),
    .clr      (finish),  // back to zero before the next request
    .en       (ramp_en),
    .count    (ramp),
    .overflow (ramp_ovf)
  );

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start) state_nxt = LOAD;
      LOAD:    if (ramp_ovf) state_nxt = MUL;
      MUL:     if (ramp_ovf) state_nxt = DONE;
      DONE:    if (finish) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // operands held for the whole fill
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_a <= '0;
      op_b <= '0;
    end else if (start) begin
      op_a <= in_a;
      op_b <= in_b;
    end
  end

endmodule

//--- src/sc_pkg.sv
`include "sc_defs.svh"

package sc_pkg;

  // controller phases
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    MUL  = 2'd2,
    DONE = 2'd3
  } sc_phase_t;

  typedef logic [`SC_OPW-1:0] operand_t;  // operand or ramp value

  typedef logic [`SC_LEN-1:0] stream_t;   // unary stream

  typedef logic [`SC_RESW-1:0] result_t;

endpackage

//--- src/sc_result_stage.sv
`timescale 1ns/10ps

module sc_result_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            finish,
  input  sc_pkg::result_t in_c,
  input  sc_pkg::result_t sum,
  input  logic            out_ready,
  output logic            out_valid,
  output sc_pkg::result_t out_data,
  output logic            res_full
);

  import sc_pkg::*;

  result_t c_q;  // offset for the request in flight

  assign res_full = out_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      c_q <= '0;
    end else if (start) begin
      c_q <= in_c;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else if (finish) begin
      out_valid <= 1'b1;
      out_data  <= sum + c_q;  // wraps mod 256
    end else if (out_valid && out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

//--- src/sn_stream_reg.sv
`timescale 1ns/10ps
`include "sc_defs.svh"

module sn_stream_reg (
  input  logic             clk,
  input  logic             rst,
  input  sc_pkg::operand_t level,
  input  sc_pkg::operand_t ramp,
  input  logic             fill,
  input  logic             rotate,
  output sc_pkg::stream_t  stream
);

  import sc_pkg::*;

  operand_t thresh;
  logic     cmp_bit;

  // ramp leads the fill by one step
  // 16 - ramp lands level > k in bit k after the last shift
  assign thresh  = '0 - ramp;
  assign cmp_bit = (level > thresh);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stream <= '0;
    end else if (fill) begin
      stream <= {stream[`SC_LEN-2:0], cmp_bit};
    end else if (rotate) begin
      stream <= {stream[`SC_LEN-2:0], stream[`SC_LEN-1]};  // rotate left
    end
  end

endmodule

//--- test/sc_mul_assert.sv
`timescale 1ns/10ps

module sc_mul_assert (
  input logic            clk,
  input logic            rst,
  input logic            in_valid,
  input logic            in_ready,
  input logic            fill,
  input logic            rotate,
  input logic            out_valid,
  input logic            out_ready,
  input sc_pkg::result_t out_data
);

  // stalled result must not move
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_data or out_valid changed while stalled");

  // busy from acceptance into DONE, 16 edges per phase
  a_busy: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) |=>
      (fill && !in_ready) ##16 (rotate && !in_ready) ##16 !in_ready)
    else $error("phase sequence wrong or in_ready high during a computation");

  // nothing can finish straight out of reset
  a_reset: assert property (@(posedge clk)
    rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

//--- test/sc_mul_golden.txt
// columns: a b c expected, all hex
// expected = a*b + c mod 256
0 0 00 00
0 f 12 12
f 0 34 34
f f 00 e1
3 5 07 16
f f 1f 00
7 9 ff 3e
1 1 00 01
8 8 c0 00
c d a5 41
2 e 10 2c
a 5 80 b2
6 b f0 32
9 4 03 27
e 1 fe 0c
5 c 44 80
f d 2b ee
4 7 e0 fc

//--- test/tb_sc_mul.sv
`timescale 1ns/10ps

module tb_sc_mul;

  import sc_pkg::*;

  localparam int N_REQ     = 18;
  localparam int CYC_LIMIT = 40 * N_REQ + 200;

  logic     clk;
  logic     rst;
  logic     in_valid;
  operand_t in_a;
  operand_t in_b;
  result_t  in_c;
  logic     out_ready;
  logic     in_ready;
  logic     out_valid;
  result_t  out_data;

  logic [7:0]  gold_mem [0:4*N_REQ-1];  // a, b, c, expected per request
  logic [7:0]  exp_q [$];
  int          acc_q [$];                // negedge count at acceptance
  logic [15:0] lfsr = 16'd59520;
  int          ready_mode = 0;           // 0 high, 1 random, 2 low
  bit          lat_check = 1'b1;
  int          cur_idx = 0;
  int          taken = 0;
  int          ncyc = 0;

  sc_mul_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_c      (in_c),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  bind sc_mul_top sc_mul_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .fill      (fill),
    .rotate    (rotate),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // taps 16 14 13 11
  function automatic logic random_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return lfsr[0];
  endfunction

  function automatic logic [7:0] model_result(input logic [7:0] a, input logic [7:0] b,
                                              input logic [7:0] c);
    logic [15:0] full;
    full = 16'(a) * 16'(b) + 16'(c);
    return full[7:0];  // mod 256
  endfunction

  task automatic send_request(input int idx, input bit use_gap);
    int   gap;
    logic b1;
    logic b0;
    gap = 0;
    @(negedge clk);
    if (use_gap) begin
      b1  = random_bit();
      b0  = random_bit();
      gap = int'({b1, b0});
    end
    repeat (gap) @(negedge clk);
    @(posedge clk);
    cur_idx = idx;
    in_valid <= 1'b1;
    in_a     <= gold_mem[4*idx][3:0];
    in_b     <= gold_mem[4*idx+1][3:0];
    in_c     <= gold_mem[4*idx+2];
    do @(negedge clk); while (!in_ready);
    @(posedge clk);  // accepted on this edge
    in_valid <= 1'b0;
  endtask

  task automatic wait_taken(input int n);
    while (taken < n) @(posedge clk);
  endtask

  // sink side
  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      case (ready_mode)
        0:       out_ready <= 1'b1;
        1:       out_ready <= random_bit();
        default: out_ready <= 1'b0;
      endcase
    end
  end

  // monitor, everything sampled at the falling edge
  initial begin : monitor
    logic       prev_valid;
    logic       prev_ready;
    logic [7:0] prev_data;
    int         acc_time;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_data  = '0;
    forever begin
      @(negedge clk);
      ncyc++;
      if (ncyc > CYC_LIMIT) begin
        abort_run($sformatf("run timed out after %0d cycles", CYC_LIMIT));
      end
      if (!rst) begin
        if (prev_valid && !prev_ready) begin
          check_value("out_valid held under stall", 1, 32'(out_valid));
          check_value("out_data held under stall", 32'(prev_data), 32'(out_data));
        end
        if (out_valid && !prev_valid) begin
          if (acc_q.size() == 0) begin
            abort_run("a result appeared with no request outstanding");
          end
          acc_time = acc_q.pop_front();
          if (lat_check) check_value("latency", 33, 32'(ncyc - acc_time - 1));
        end
        if (out_valid && out_ready) begin
          if (exp_q.size() == 0) begin
            abort_run("a result was taken with no expected value queued");
          end
          check_value($sformatf("result %0d", taken), 32'(exp_q.pop_front()), 32'(out_data));
          taken++;
        end
        if (in_valid && in_ready) begin
          exp_q.push_back(gold_mem[4*cur_idx+3]);
          acc_q.push_back(ncyc);
        end
      end
      prev_valid = out_valid;
      prev_ready = out_ready;
      prev_data  = out_data;
    end
  end

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_a     = '0;
    in_b     = '0;
    in_c     = '0;
    $readmemh("test/sc_mul_golden.txt", gold_mem);
    for (int i = 0; i < N_REQ; i++) begin
      check_value($sformatf("golden entry %0d", i),
                  32'(model_result(gold_mem[4*i], gold_mem[4*i+1], gold_mem[4*i+2])),
                  32'(gold_mem[4*i+3]));
    end

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("in_ready after reset", 1, 32'(in_ready));
    check_value("out_valid after reset", 0, 32'(out_valid));

    // sink always ready, fixed latency
    for (int i = 0; i < 6; i++) send_request(i, 1'b0);
    wait_taken(6);
    lat_check = 1'b0;
    @(negedge clk);
    ready_mode = 1;

    // random stalls and gaps
    for (int i = 6; i < 16; i++) send_request(i, 1'b1);
    wait_taken(16);
    @(negedge clk);
    ready_mode = 2;

    // second request while the first result waits
    send_request(16, 1'b0);
    do @(negedge clk); while (!out_valid);
    check_value("in_ready with a result parked", 1, 32'(in_ready));
    send_request(17, 1'b0);
    repeat (40) @(negedge clk);
    check_value("in_ready while stalled in DONE", 0, 32'(in_ready));
    check_value("out_valid while stalled", 1, 32'(out_valid));
    ready_mode = 0;
    wait_taken(N_REQ);
    repeat (40) @(negedge clk);
    check_value("out_valid after the last take", 0, 32'(out_valid));

    $display("Regression passed");
    $finish;
  end

endmodule
